/* src/ooo_pkg.sv */
package ooo_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int xlen       = 32;
    localparam int arch_regs  = 8;
    localparam int phys_regs  = 16;
    localparam int rob_depth  = 8;
    localparam int iq_depth   = 4;
    localparam int mul_stages = 3;

    typedef logic [2:0] areg_t;
    typedef logic [3:0] preg_t;
    typedef logic [2:0] rob_idx_t;

    // ====================
    // Operations
    // ====================
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_mul = 3'd5,
        op_li  = 3'd6
    } op_t;

    // Decoded instruction at the input
    typedef struct packed {
        op_t         op;
        areg_t       rd;
        areg_t       rs1;
        areg_t       rs2;
        logic [15:0] imm;
    } inst_t;

    // Rename result, rdy bits already include a same-cycle result
    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        logic  rdy1;
        logic  rdy2;
        preg_t prd;
        preg_t old_prd;
    } renamed_t;

    typedef struct packed {
        op_t         op;
        preg_t       prs1;
        preg_t       prs2;
        preg_t       prd;
        rob_idx_t    rob_idx;
        logic [15:0] imm;
    } issue_t;

    // One lane of the result bus
    typedef struct packed {
        logic            valid;
        preg_t           prd;
        rob_idx_t        rob_idx;
        logic [xlen-1:0] value;
    } cdb_t;

    typedef struct packed {
        areg_t           rd;
        logic [xlen-1:0] value;
    } retire_t;

endpackage

/* src/pipeline_ctrl.sv */
`timescale 1ns/1ps

module pipeline_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    output logic              retire_valid,
    input  logic              retire_ready,
    input  logic              free_avail,
    input  logic              iq_full,
    input  logic              head_done,
    input  ooo_pkg::preg_t    head_old_prd,
    output logic              alloc_fire,
    output ooo_pkg::rob_idx_t alloc_idx,
    output ooo_pkg::rob_idx_t head_idx,
    output logic              free_en,
    output ooo_pkg::preg_t    free_prd
);
    import ooo_pkg::*;

    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    logic [3:0] count_q;
    logic       rob_room;
    logic       retire_fire;

    // Occupancy runs 0 to rob_depth, one bit wider than the index
    assign rob_room   = (count_q != 4'(rob_depth));
    assign in_ready   = free_avail && rob_room && !iq_full;
    assign alloc_fire = in_valid && in_ready;
    assign alloc_idx  = tail_q;

    // Done bit of an empty head slot is left over from the last retire
    assign retire_valid = head_done && (count_q != 4'd0);
    assign retire_fire  = retire_valid && retire_ready;
    assign head_idx     = head_q;

    // Retiring frees the previous mapping of rd
    assign free_en  = retire_fire;
    assign free_prd = head_old_prd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_fire, retire_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* src/rename_map.sv */
`timescale 1ns/1ps

module rename_map (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_fire,
    input  ooo_pkg::inst_t      in_inst,
    input  ooo_pkg::cdb_t [1:0] cdb,
    input  logic                free_en,
    input  ooo_pkg::preg_t      free_prd,
    output logic                free_avail,
    output ooo_pkg::renamed_t   renamed
);
    import ooo_pkg::*;

    preg_t                map_q [arch_regs];
    logic [phys_regs-1:0] busy_q;
    logic [phys_regs-1:0] cdb_hit;

    // Free list FIFO, never more than phys_regs - arch_regs entries
    preg_t      free_q [phys_regs-arch_regs];
    logic [2:0] rd_ptr_q;
    logic [2:0] wr_ptr_q;
    logic [3:0] free_cnt_q;

    always_comb begin
        cdb_hit = '0;
        for (int k = 0; k < 2; k++) begin
            if (cdb[k].valid) begin
                cdb_hit[cdb[k].prd] = 1'b1;
            end
        end
    end

    assign free_avail = (free_cnt_q != 4'd0);

    // Sources read the map before this instruction's own update
    assign renamed.prs1    = map_q[in_inst.rs1];
    assign renamed.prs2    = map_q[in_inst.rs2];
    assign renamed.rdy1    = !busy_q[renamed.prs1] || cdb_hit[renamed.prs1];
    assign renamed.rdy2    = !busy_q[renamed.prs2] || cdb_hit[renamed.prs2];
    assign renamed.prd     = free_q[rd_ptr_q];
    assign renamed.old_prd = map_q[in_inst.rd];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                map_q[i] <= preg_t'(i);
            end
            for (int i = 0; i < phys_regs - arch_regs; i++) begin
                free_q[i] <= preg_t'(arch_regs + i);
            end
            busy_q     <= '0;
            rd_ptr_q   <= '0;
            wr_ptr_q   <= '0;
            free_cnt_q <= 4'(phys_regs - arch_regs);
        end else begin
            busy_q <= busy_q & ~cdb_hit;
            if (alloc_fire) begin
                map_q[in_inst.rd]    <= renamed.prd;
                busy_q[renamed.prd]  <= 1'b1;
                rd_ptr_q             <= rd_ptr_q + 1'b1;
            end
            if (free_en) begin
                free_q[wr_ptr_q] <= free_prd;
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end
            case ({alloc_fire, free_en})
                2'b10:   free_cnt_q <= free_cnt_q - 1'b1;
                2'b01:   free_cnt_q <= free_cnt_q + 1'b1;
                default: free_cnt_q <= free_cnt_q;
            endcase
        end
    end

endmodule

/* src/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_fire,
    input  ooo_pkg::rob_idx_t   alloc_idx,
    input  ooo_pkg::inst_t      in_inst,
    input  ooo_pkg::renamed_t   renamed,
    input  ooo_pkg::cdb_t [1:0] cdb,
    output logic                iq_full,
    output logic                issue_valid,
    output ooo_pkg::issue_t     issue
);
    import ooo_pkg::*;

    typedef logic [$clog2(iq_depth)-1:0] slot_t;

    logic [iq_depth-1:0] valid_q;
    logic [iq_depth-1:0] rdy1_q;
    logic [iq_depth-1:0] rdy2_q;
    issue_t              entry_q [iq_depth];
    logic [iq_depth-1:0] wake1;
    logic [iq_depth-1:0] wake2;
    logic [iq_depth-1:0] ready;
    slot_t               free_slot;
    slot_t               sel_slot;
    logic                no_src;

    // ====================
    // Wakeup
    // ====================
    always_comb begin
        wake1 = '0;
        wake2 = '0;
        for (int i = 0; i < iq_depth; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (cdb[k].valid && (cdb[k].prd == entry_q[i].prs1)) begin
                    wake1[i] = 1'b1;
                end
                if (cdb[k].valid && (cdb[k].prd == entry_q[i].prs2)) begin
                    wake2[i] = 1'b1;
                end
            end
        end
    end

    // ====================
    // Select
    // ====================
    assign ready   = valid_q & rdy1_q & rdy2_q;
    assign iq_full = &valid_q;

    // Scan downward so the lowest slot wins
    always_comb begin
        free_slot = '0;
        sel_slot  = '0;
        for (int i = iq_depth - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_slot = slot_t'(i);
            end
            if (ready[i]) begin
                sel_slot = slot_t'(i);
            end
        end
    end

    assign issue_valid = |ready;
    assign issue       = entry_q[sel_slot];

    // LI has no register sources
    assign no_src = (in_inst.op == op_li);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            rdy1_q  <= '0;
            rdy2_q  <= '0;
        end else begin
            rdy1_q <= rdy1_q | wake1;
            rdy2_q <= rdy2_q | wake2;
            if (issue_valid) begin
                valid_q[sel_slot] <= 1'b0;
            end
            if (alloc_fire) begin
                valid_q[free_slot] <= 1'b1;
                rdy1_q[free_slot]  <= renamed.rdy1 || no_src;
                rdy2_q[free_slot]  <= renamed.rdy2 || no_src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entry_q[free_slot] <= '{op:      in_inst.op,
                                    prs1:    renamed.prs1,
                                    prs2:    renamed.prs2,
                                    prd:     renamed.prd,
                                    rob_idx: alloc_idx,
                                    imm:     in_inst.imm};
        end
    end

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  ooo_pkg::issue_t           issue,
    input  logic [ooo_pkg::xlen-1:0]  src1,
    input  logic [ooo_pkg::xlen-1:0]  src2,
    output ooo_pkg::cdb_t [1:0]       cdb
);
    import ooo_pkg::*;

    logic                  is_mul;
    logic [xlen-1:0]       alu_result;
    logic                  alu_valid_q;
    preg_t                 alu_prd_q;
    rob_idx_t              alu_rob_q;
    logic [xlen-1:0]       alu_value_q;
    logic [mul_stages-1:0] mul_valid_q;
    preg_t                 mul_prd_q   [mul_stages];
    rob_idx_t              mul_rob_q   [mul_stages];
    logic [xlen-1:0]       mul_value_q [mul_stages];

    assign is_mul = (issue.op == op_mul);

    always_comb begin
        case (issue.op)
            op_add:  alu_result = src1 + src2;
            op_sub:  alu_result = src1 - src2;
            op_and:  alu_result = src1 & src2;
            op_or:   alu_result = src1 | src2;
            op_xor:  alu_result = src1 ^ src2;
            op_li:   alu_result = {{(xlen-16){issue.imm[15]}}, issue.imm};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= '0;
        end else begin
            alu_valid_q <= issue_valid && !is_mul;
            mul_valid_q <= {mul_valid_q[mul_stages-2:0], issue_valid && is_mul};
        end
    end

    always_ff @(posedge clk) begin
        alu_prd_q   <= issue.prd;
        alu_rob_q   <= issue.rob_idx;
        alu_value_q <= alu_result;
        // Product taken in xlen context, upper half dropped
        mul_prd_q[0]   <= issue.prd;
        mul_rob_q[0]   <= issue.rob_idx;
        mul_value_q[0] <= src1 * src2;
        for (int s = 1; s < mul_stages; s++) begin
            mul_prd_q[s]   <= mul_prd_q[s-1];
            mul_rob_q[s]   <= mul_rob_q[s-1];
            mul_value_q[s] <= mul_value_q[s-1];
        end
    end

    assign cdb[0] = '{valid: alu_valid_q, prd: alu_prd_q,
                      rob_idx: alu_rob_q, value: alu_value_q};
    assign cdb[1] = '{valid: mul_valid_q[mul_stages-1], prd: mul_prd_q[mul_stages-1],
                      rob_idx: mul_rob_q[mul_stages-1], value: mul_value_q[mul_stages-1]};

endmodule

/* src/rob_store.sv */
`timescale 1ns/1ps

module rob_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_fire,
    input  ooo_pkg::rob_idx_t   alloc_idx,
    input  ooo_pkg::inst_t      in_inst,
    input  ooo_pkg::renamed_t   renamed,
    input  ooo_pkg::cdb_t [1:0] cdb,
    input  ooo_pkg::rob_idx_t   head_idx,
    output logic                head_done,
    output ooo_pkg::preg_t      head_old_prd,
    output ooo_pkg::retire_t    retire_data
);
    import ooo_pkg::*;

    areg_t                rd_q      [rob_depth];
    preg_t                old_prd_q [rob_depth];
    logic [xlen-1:0]      value_q   [rob_depth];
    logic [rob_depth-1:0] done_q;

    // ====================
    // Completion state
    // ====================
    // A completing entry is always in flight, never the one being allocated
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            if (alloc_fire) begin
                done_q[alloc_idx] <= 1'b0;
            end
            for (int k = 0; k < 2; k++) begin
                if (cdb[k].valid) begin
                    done_q[cdb[k].rob_idx] <= 1'b1;
                end
            end
        end
    end

    // ====================
    // Entry payload
    // ====================
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[alloc_idx]      <= in_inst.rd;
            old_prd_q[alloc_idx] <= renamed.old_prd;
        end
        for (int k = 0; k < 2; k++) begin
            if (cdb[k].valid) begin
                value_q[cdb[k].rob_idx] <= cdb[k].value;
            end
        end
    end

    // Head view, stable until the head pointer moves
    assign head_done    = done_q[head_idx];
    assign head_old_prd = old_prd_q[head_idx];
    assign retire_data  = '{rd: rd_q[head_idx], value: value_q[head_idx]};

endmodule

/* src/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ooo_pkg::cdb_t [1:0]      cdb,
    input  ooo_pkg::preg_t           rtag1,
    input  ooo_pkg::preg_t           rtag2,
    output logic [ooo_pkg::xlen-1:0] rdata1,
    output logic [ooo_pkg::xlen-1:0] rdata2
);
    import ooo_pkg::*;

    logic [xlen-1:0] rf_q [phys_regs];

    // Initial mappings of the architectural registers read as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < phys_regs; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (cdb[k].valid) begin
                    rf_q[cdb[k].prd] <= cdb[k].value;
                end
            end
        end
    end

    assign rdata1 = rf_q[rtag1];
    assign rdata2 = rf_q[rtag2];

endmodule

/* src/ooo_slice_top.sv */
`timescale 1ns/1ps

module ooo_slice_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  ooo_pkg::inst_t   in_inst,
    output logic             retire_valid,
    input  logic             retire_ready,
    output ooo_pkg::retire_t retire_data
);
    import ooo_pkg::*;

    // ====================
    // Allocation and retire
    // ====================
    logic     alloc_fire;
    rob_idx_t alloc_idx;
    rob_idx_t head_idx;
    logic     free_avail;
    logic     iq_full;
    logic     head_done;
    preg_t    head_old_prd;
    logic     free_en;
    preg_t    free_prd;
    renamed_t renamed;

    // ====================
    // Issue and results
    // ====================
    logic            issue_valid;
    issue_t          issue;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    cdb_t [1:0]      cdb;

    pipeline_ctrl i_pipeline_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .free_avail   (free_avail),
        .iq_full      (iq_full),
        .head_done    (head_done),
        .head_old_prd (head_old_prd),
        .alloc_fire   (alloc_fire),
        .alloc_idx    (alloc_idx),
        .head_idx     (head_idx),
        .free_en      (free_en),
        .free_prd     (free_prd)
    );

    rename_map i_rename_map (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_fire (alloc_fire),
        .in_inst    (in_inst),
        .cdb        (cdb),
        .free_en    (free_en),
        .free_prd   (free_prd),
        .free_avail (free_avail),
        .renamed    (renamed)
    );

    issue_queue i_issue_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_fire  (alloc_fire),
        .alloc_idx   (alloc_idx),
        .in_inst     (in_inst),
        .renamed     (renamed),
        .cdb         (cdb),
        .iq_full     (iq_full),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    // Operands are read in the issue cycle
    phys_regfile i_phys_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .cdb    (cdb),
        .rtag1  (issue.prs1),
        .rtag2  (issue.prs2),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    exec_unit i_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .src1        (src1),
        .src2        (src2),
        .cdb         (cdb)
    );

    rob_store i_rob_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_fire   (alloc_fire),
        .alloc_idx    (alloc_idx),
        .in_inst      (in_inst),
        .renamed      (renamed),
        .cdb          (cdb),
        .head_idx     (head_idx),
        .head_done    (head_done),
        .head_old_prd (head_old_prd),
        .retire_data  (retire_data)
    );

endmodule

/* bench/tb_ooo_slice.sv */
`timescale 1ns/1ps

module tb_ooo_slice;
    import ooo_pkg::*;

    localparam int clk_period = 20;
    localparam int stim_delay = 2;
    localparam int wait_limit = 200;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    inst_t   in_inst;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire_data;

    inst_t           stim_q [$];
    int              gap_q  [$];
    retire_t         exp_q  [$];
    logic [xlen-1:0] arch_model [arch_regs];
    integer          seed;
    logic            toggle_ready;
    int              errors;
    int              checks;
    int              sent;
    int              retired;

    ooo_slice_top i_ooo_slice_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_inst      (in_inst),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_data  (retire_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // ====================
    // Helpers
    // ====================
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // In-order model of the architectural registers
    function automatic retire_t ref_execute(input inst_t inst);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        retire_t         res;
        a = arch_model[inst.rs1];
        b = arch_model[inst.rs2];
        case (inst.op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_mul:  r = a * b;
            op_li:   r = {{16{inst.imm[15]}}, inst.imm};
            default: r = '0;
        endcase
        arch_model[inst.rd] = r;
        res.rd    = inst.rd;
        res.value = r;
        return res;
    endfunction

    function automatic inst_t make_inst(input op_t op, input areg_t rd, input areg_t rs1,
                                        input areg_t rs2, input logic [15:0] imm);
        inst_t inst;
        inst.op  = op;
        inst.rd  = rd;
        inst.rs1 = rs1;
        inst.rs2 = rs2;
        inst.imm = imm;
        return inst;
    endfunction

    task automatic queue_inst(input inst_t inst, input int gap);
        stim_q.push_back(inst);
        gap_q.push_back(gap);
    endtask

    // Drives queued instructions onto the input handshake
    task automatic send_all();
        inst_t inst;
        int    gap;
        int    n;
        logic  fired;
        while (stim_q.size() > 0) begin
            inst = stim_q.pop_front();
            gap  = gap_q.pop_front();
            repeat (gap) begin
                @(posedge clk);
                #stim_delay;
            end
            in_valid = 1'b1;
            in_inst  = inst;
            fired    = 1'b0;
            n        = 0;
            while (!fired && n < wait_limit) begin
                @(negedge clk);
                fired = in_ready;
                @(posedge clk);
                #stim_delay;
                n++;
            end
            in_valid = 1'b0;
            if (fired) begin
                // Expected result only once the DUT has taken it
                exp_q.push_back(ref_execute(inst));
                sent++;
            end else begin
                errors++;
                $display("Timeout at %0t waiting for the DUT to accept an instruction", $time);
                stim_q.delete();
                gap_q.delete();
            end
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 5 * wait_limit) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        #stim_delay;
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout in %s, %0d instructions never retired", what, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic wait_in_ready_low();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            seen = !in_ready;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("Timeout waiting for in_ready to fall while retire_ready is low");
        end
    endtask

    // ====================
    // Retire side
    // ====================
    always @(posedge clk) begin
        #stim_delay;
        if (toggle_ready) begin
            retire_ready = ($unsigned($random(seed)) % 3) != 0;
        end
    end

    // Transfer happens at the next rising edge
    always @(negedge clk) begin
        if (rst_n && retire_valid && retire_ready) begin
            retired++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Retire at %0t with no instruction left to retire", $time);
            end else begin
                check_value("retired rd and value", retire_data, exp_q.pop_front());
            end
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        inst_t rnd_inst;
        int    gap;
        int    sent_before;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_inst      = '0;
        retire_ready = 1'b0;
        toggle_ready = 1'b0;
        seed         = 32'h536;
        errors       = 0;
        checks       = 0;
        sent         = 0;
        retired      = 0;
        sent_before  = 0;
        for (int i = 0; i < arch_regs; i++) begin
            arch_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #stim_delay;
        rst_n        = 1'b1;
        retire_ready = 1'b1;
        @(negedge clk);
        check_value("retire_valid after reset", retire_valid, 1'b0);
        check_value("in_ready after reset", in_ready, 1'b1);
        @(posedge clk);
        #stim_delay;

        // Load every register with some negative immediates
        queue_inst(make_inst(op_li, 3'd0, 3'd0, 3'd0, 16'h0005), 0);
        queue_inst(make_inst(op_li, 3'd1, 3'd0, 3'd0, 16'hfffd), 0);
        queue_inst(make_inst(op_li, 3'd2, 3'd0, 3'd0, 16'h1234), 0);
        queue_inst(make_inst(op_li, 3'd3, 3'd0, 3'd0, 16'h8000), 0);
        queue_inst(make_inst(op_li, 3'd4, 3'd0, 3'd0, 16'h7fff), 0);
        queue_inst(make_inst(op_li, 3'd5, 3'd0, 3'd0, 16'hffff), 0);
        queue_inst(make_inst(op_li, 3'd6, 3'd0, 3'd0, 16'h00a5), 0);
        queue_inst(make_inst(op_li, 3'd7, 3'd0, 3'd0, 16'hc350), 0);
        send_all();
        wait_drain("LI sequence");

        // One of each operation
        queue_inst(make_inst(op_add, 3'd0, 3'd1, 3'd2, 16'h0), 0);
        queue_inst(make_inst(op_sub, 3'd3, 3'd4, 3'd5, 16'h0), 0);
        queue_inst(make_inst(op_and, 3'd6, 3'd7, 3'd2, 16'h0), 0);
        queue_inst(make_inst(op_or,  3'd1, 3'd3, 3'd6, 16'h0), 0);
        queue_inst(make_inst(op_xor, 3'd2, 3'd4, 3'd7, 16'h0), 0);
        queue_inst(make_inst(op_mul, 3'd5, 3'd1, 3'd7, 16'h0), 0);
        queue_inst(make_inst(op_mul, 3'd4, 3'd4, 3'd4, 16'h0), 0);
        send_all();
        wait_drain("operation sequence");

        // Slow MUL overtaken by independent ADDs and followed by a MUL consumer
        queue_inst(make_inst(op_mul, 3'd3, 3'd2, 3'd7, 16'h0), 0);
        queue_inst(make_inst(op_add, 3'd0, 3'd1, 3'd1, 16'h0), 0);
        queue_inst(make_inst(op_add, 3'd6, 3'd5, 3'd4, 16'h0), 0);
        queue_inst(make_inst(op_sub, 3'd1, 3'd0, 3'd6, 16'h0), 0);
        queue_inst(make_inst(op_xor, 3'd7, 3'd3, 3'd0, 16'h0), 0);
        send_all();
        wait_drain("MUL ordering sequence");

        // Stalled retire fills the reorder buffer
        retire_ready = 1'b0;
        sent_before  = sent;
        for (int i = 0; i < 12; i++) begin
            queue_inst(make_inst(op_t'((i % 2) ? op_add : op_li), areg_t'(i),
                                 areg_t'(i + 1), areg_t'(i + 2), 16'(i * 3 - 7)), 0);
        end
        fork
            send_all();
            begin
                wait_in_ready_low();
                repeat (5) @(posedge clk);
                #stim_delay;
                check_value("instructions accepted while retire is stalled",
                            sent - sent_before, rob_depth);
                retire_ready = 1'b1;
            end
        join
        wait_drain("back-pressure sequence");

        // Random stream with idle gaps and a toggling retire_ready
        for (int i = 0; i < 200; i++) begin
            rnd_inst.op  = op_t'($unsigned($random(seed)) % 7);
            rnd_inst.rd  = areg_t'($random(seed));
            rnd_inst.rs1 = areg_t'($random(seed));
            rnd_inst.rs2 = areg_t'($random(seed));
            rnd_inst.imm = 16'($random(seed));
            gap          = $unsigned($random(seed)) % 6;
            if (gap > 3) begin
                gap = 0;
            end
            queue_inst(rnd_inst, gap);
        end
        toggle_ready = 1'b1;
        send_all();
        toggle_ready = 1'b0;
        retire_ready = 1'b1;
        wait_drain("random stream");

        check_value("retired instruction count", retired, sent);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/ooo_pkg.sv
src/pipeline_ctrl.sv
src/rename_map.sv
src/issue_queue.sv
src/exec_unit.sv
src/rob_store.sv
src/phys_regfile.sv
src/ooo_slice_top.sv
bench/tb_ooo_slice.sv

/* Bender.yml */
package:
  name: ooo_slice

sources:
  - src/ooo_pkg.sv
  - src/pipeline_ctrl.sv
  - src/rename_map.sv
  - src/issue_queue.sv
  - src/exec_unit.sv
  - src/rob_store.sv
  - src/phys_regfile.sv
  - src/ooo_slice_top.sv
  - target: simulation
    files:
      - bench/tb_ooo_slice.sv
